// ==== rtl/icache_pkg.sv ====
package icache_pkg;

    // address split: | tag | index | word | byte |
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_SEL_W     = 2;
    localparam int BYTE_OFF_W     = 4;    // byte + word offset inside a line
    localparam int INDEX_W        = 4;
    localparam int NUM_SETS       = 1 << INDEX_W;
    localparam int TAG_W          = ADDR_W - INDEX_W - BYTE_OFF_W;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;

    // set index into the way arrays
    typedef logic [INDEX_W-1:0] index_t;

    typedef logic [TAG_W-1:0] tag_t;

    // word 0 in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // cache operations accepted on the cacop port
    typedef enum logic {
        CACOP_INDEX_INV = 1'b0,   // clear way addr[0] at the index
        CACOP_HIT_INV   = 1'b1    // clear the way that hits, if any
    } cacop_code_t;

    // one-hot way mask, bit 0 is way 0
    typedef logic [1:0] way_sel_t;

endpackage

// ==== rtl/way_ram.sv ====
`timescale 1ns/1ps

module way_ram #(
    parameter type payload_t = logic [31:0]
) (
    input  logic               clk,
    input  icache_pkg::index_t i_raddr,
    input  icache_pkg::index_t i_waddr,
    input  logic               i_we,
    input  payload_t           i_wdata,
    output payload_t           o_rdata
);
    import icache_pkg::*;

    // one entry per set
    payload_t mem [NUM_SETS];

    // registered read
    // a same-cycle write shows up only on the next read
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

endmodule

// ==== rtl/icache_lookup.sv ====
`timescale 1ns/1ps

module icache_lookup (
    input  logic [icache_pkg::ADDR_W-1:0] i_req_addr,
    input  icache_pkg::tag_t              i_tag0,
    input  icache_pkg::tag_t              i_tag1,
    input  icache_pkg::way_sel_t          i_valid,
    input  icache_pkg::line_t             i_line0,
    input  icache_pkg::line_t             i_line1,
    output logic                          o_hit,
    output icache_pkg::way_sel_t          o_hit_way,
    output logic [icache_pkg::WORD_W-1:0] o_word
);
    import icache_pkg::*;

    tag_t                  req_tag;
    logic [WORD_SEL_W-1:0] word_sel;
    way_sel_t              hit_vec;
    line_t                 hit_line;

    assign req_tag  = i_req_addr[ADDR_W-1 -: TAG_W];
    assign word_sel = i_req_addr[BYTE_OFF_W-1 -: WORD_SEL_W];

    // a stored tag only counts with its valid bit
    assign hit_vec[0] = i_valid[0] && (i_tag0 == req_tag);
    assign hit_vec[1] = i_valid[1] && (i_tag1 == req_tag);

    assign o_hit = |hit_vec;

    // both ways never hold the same tag, way 0 wins anyway
    always_comb begin
        if (hit_vec[0]) begin
            o_hit_way = 2'b01;
        end else begin
            o_hit_way = hit_vec;
        end
    end

    assign hit_line = o_hit_way[1] ? i_line1 : i_line0;

    always_comb begin
        case (word_sel)
            2'd0:    o_word = hit_line[0*WORD_W +: WORD_W];
            2'd1:    o_word = hit_line[1*WORD_W +: WORD_W];
            2'd2:    o_word = hit_line[2*WORD_W +: WORD_W];
            default: o_word = hit_line[3*WORD_W +: WORD_W];
        endcase
    end

endmodule

// ==== rtl/refill_engine.sv ====
`timescale 1ns/1ps

module refill_engine (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_start,
    input  logic [icache_pkg::ADDR_W-1:0] i_line_addr,
    output icache_pkg::line_t             o_line,
    output logic                          o_line_valid,
    // wishbone classic, read only so WE stays low on the bus
    output logic                          o_wb_cyc,
    output logic                          o_wb_stb,
    output logic [icache_pkg::ADDR_W-1:0] o_wb_adr,
    input  logic [icache_pkg::WORD_W-1:0] i_wb_dat,
    input  logic                          i_wb_ack
);
    import icache_pkg::*;

    logic                         busy_q;
    logic [WORD_SEL_W-1:0]        beat_q;     // word being fetched
    logic [ADDR_W-1:BYTE_OFF_W]   base_q;     // line address without offset
    line_t                        line_q;
    logic                         line_valid_q;
    logic                         launch;
    logic                         beat_done;

    assign launch    = i_start && !busy_q;
    assign beat_done = busy_q && i_wb_ack;

    // control
    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy_q       <= 1'b0;
            beat_q       <= '0;
            line_valid_q <= 1'b0;
        end else begin
            line_valid_q <= 1'b0;
            if (launch) begin
                busy_q <= 1'b1;
                beat_q <= '0;
            end else if (beat_done) begin
                beat_q <= beat_q + 1'b1;   // wraps to 0 after the last beat
                if (beat_q == WORD_SEL_W'(WORDS_PER_LINE - 1)) begin
                    busy_q       <= 1'b0;  // cyc drops after last ack
                    line_valid_q <= 1'b1;
                end
            end
        end
    end

    // line address and line buffer
    always_ff @(posedge clk) begin
        if (launch) begin
            base_q <= i_line_addr[ADDR_W-1:BYTE_OFF_W];
        end
        if (beat_done) begin
            line_q[beat_q*WORD_W +: WORD_W] <= i_wb_dat;
        end
    end

    // cyc and stb stay up for the whole burst of four beats
    assign o_wb_cyc = busy_q;
    assign o_wb_stb = busy_q;
    assign o_wb_adr = {base_q, beat_q, 2'b00};   // base, +4, +8, +12

    assign o_line       = line_q;
    assign o_line_valid = line_valid_q;

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_req_valid,
    input  logic [icache_pkg::ADDR_W-1:0] i_req_addr,
    output logic                          o_req_ready,
    output logic                          o_resp_valid,
    output logic                          o_resp_fault,
    input  logic                          i_cacop_valid,
    input  icache_pkg::cacop_code_t       i_cacop_code,
    input  logic [icache_pkg::ADDR_W-1:0] i_cacop_addr,
    output logic                          o_cacop_ready,
    output logic                          o_cacop_done,
    output icache_pkg::index_t            o_rd_index,
    output icache_pkg::index_t            o_wr_index,
    output logic [icache_pkg::ADDR_W-1:0] o_req_addr_q,
    output icache_pkg::way_sel_t          o_valid,
    input  logic                          i_hit,
    input  icache_pkg::way_sel_t          i_hit_way,
    output icache_pkg::way_sel_t          o_tag_we,
    output icache_pkg::way_sel_t          o_line_we,
    output logic                          o_refill_start,
    input  logic                          i_line_valid,
    output logic                          o_data_from_refill
);
    import icache_pkg::*;

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS, REFILL, CACOP} state_t;

    state_t              state_q, state_d;
    logic                ready_en_q;        // high from the first cycle after reset
    logic [ADDR_W-1:0]   addr_q;            // request buffer, fetch or cacop
    cacop_code_t         code_q;
    way_sel_t            valid_q [NUM_SETS];
    logic [NUM_SETS-1:0] lru_q;             // set bit: way 1 most recently used
    way_sel_t            victim_q;
    logic                cacop_done_q;
    index_t              idx_q;
    logic                misaligned, req_acc, cacop_acc, lookup_miss, refill_done;
    way_sel_t            victim, inv_mask;

    assign idx_q      = addr_q[BYTE_OFF_W +: INDEX_W];
    assign misaligned = addr_q[1:0] != 2'b00;
    assign o_valid    = valid_q[idx_q];

    // cacop goes first in IDLE, so a fetch waits that cycle
    assign o_cacop_ready = ready_en_q && (state_q == IDLE);
    assign cacop_acc     = o_cacop_ready && i_cacop_valid;

    always_comb begin
        case (state_q)
            IDLE:    o_req_ready = ready_en_q && !i_cacop_valid;
            LOOKUP:  o_req_ready = i_hit || misaligned;   // streaming on hits
            default: o_req_ready = 1'b0;
        endcase
    end
    assign req_acc = o_req_ready && i_req_valid;

    assign lookup_miss  = (state_q == LOOKUP) && !i_hit && !misaligned;
    assign refill_done  = (state_q == REFILL) && i_line_valid;
    assign o_resp_valid = ((state_q == LOOKUP) && !lookup_miss) || refill_done;
    assign o_resp_fault = (state_q == LOOKUP) && misaligned;

    assign o_refill_start     = lookup_miss;   // cyc follows next cycle
    assign o_data_from_refill = state_q == REFILL;
    assign o_tag_we           = refill_done ? victim_q : 2'b00;
    assign o_line_we          = o_tag_we;
    assign o_wr_index         = idx_q;
    assign o_req_addr_q       = addr_q;
    assign o_cacop_done       = cacop_done_q;

    always_comb begin
        if (cacop_acc) begin
            o_rd_index = i_cacop_addr[BYTE_OFF_W +: INDEX_W];
        end else if (req_acc) begin
            o_rd_index = i_req_addr[BYTE_OFF_W +: INDEX_W];
        end else begin
            o_rd_index = idx_q;
        end
    end

    // invalid way first, else evict the one not recently used
    always_comb begin
        if (!o_valid[0]) begin
            victim = 2'b01;
        end else if (!o_valid[1]) begin
            victim = 2'b10;
        end else begin
            victim = lru_q[idx_q] ? 2'b01 : 2'b10;
        end
    end

    always_comb begin
        if (code_q == CACOP_INDEX_INV) begin
            inv_mask = addr_q[0] ? 2'b10 : 2'b01;
        end else begin
            inv_mask = i_hit ? i_hit_way : 2'b00;   // no hit, nothing cleared
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cacop_acc) begin
                    state_d = CACOP;
                end else if (req_acc) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_miss) begin
                    state_d = MISS;
                end else if (!req_acc) begin
                    state_d = IDLE;
                end
            end
            MISS:    state_d = REFILL;   // victim latched here
            REFILL:  state_d = i_line_valid ? IDLE : REFILL;
            CACOP:   state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q      <= IDLE;
            ready_en_q   <= 1'b0;
            cacop_done_q <= 1'b0;
            lru_q        <= '0;
            valid_q      <= '{default: '0};
        end else begin
            state_q      <= state_d;
            ready_en_q   <= 1'b1;
            cacop_done_q <= state_q == CACOP;   // two cycles after accept
            if ((state_q == LOOKUP) && i_hit && !misaligned) begin
                lru_q[idx_q] <= i_hit_way[1];
            end
            if (refill_done) begin
                valid_q[idx_q] <= o_valid | victim_q;
                lru_q[idx_q]   <= victim_q[1];
            end
            if (state_q == CACOP) begin
                valid_q[idx_q] <= o_valid & ~inv_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cacop_acc || req_acc) begin
            addr_q <= cacop_acc ? i_cacop_addr : i_req_addr;
        end
        if (cacop_acc) begin
            code_q <= i_cacop_code;
        end
        if (state_q == MISS) begin
            victim_q <= victim;
        end
    end

endmodule

// ==== rtl/icache_top.sv ====
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          rstn,
    // fetch port
    input  logic                          i_req_valid,
    input  logic [icache_pkg::ADDR_W-1:0] i_req_addr,
    output logic                          o_req_ready,
    output logic                          o_resp_valid,
    output logic [icache_pkg::WORD_W-1:0] o_resp_data,
    output logic                          o_resp_fault,
    // cache operations
    input  logic                          i_cacop_valid,
    input  icache_pkg::cacop_code_t       i_cacop_code,
    input  logic [icache_pkg::ADDR_W-1:0] i_cacop_addr,
    output logic                          o_cacop_ready,
    output logic                          o_cacop_done,
    // wishbone master
    output logic                          o_wb_cyc,
    output logic                          o_wb_stb,
    output logic [icache_pkg::ADDR_W-1:0] o_wb_adr,
    input  logic [icache_pkg::WORD_W-1:0] i_wb_dat,
    input  logic                          i_wb_ack
);
    import icache_pkg::*;

    index_t             rd_index, wr_index;
    logic [ADDR_W-1:0]  req_addr_q;
    way_sel_t           valid, hit_way, tag_we, line_we;
    logic               hit, refill_start, line_valid, data_from_refill;
    tag_t               tag0, tag1, wr_tag;
    line_t              line0, line1, refill_line;
    logic [WORD_W-1:0]  lookup_word, refill_word;

    assign wr_tag      = req_addr_q[ADDR_W-1 -: TAG_W];
    assign refill_word = refill_line[req_addr_q[BYTE_OFF_W-1 -: WORD_SEL_W]*WORD_W +: WORD_W];

    // fault answers carry zero data
    assign o_resp_data = o_resp_fault ? '0 : (data_from_refill ? refill_word : lookup_word);

    way_ram #(.payload_t(tag_t)) u_tag0 (
        .clk(clk), .i_raddr(rd_index), .i_waddr(wr_index),
        .i_we(tag_we[0]), .i_wdata(wr_tag), .o_rdata(tag0)
    );
    way_ram #(.payload_t(tag_t)) u_tag1 (
        .clk(clk), .i_raddr(rd_index), .i_waddr(wr_index),
        .i_we(tag_we[1]), .i_wdata(wr_tag), .o_rdata(tag1)
    );
    way_ram #(.payload_t(line_t)) u_line0 (
        .clk(clk), .i_raddr(rd_index), .i_waddr(wr_index),
        .i_we(line_we[0]), .i_wdata(refill_line), .o_rdata(line0)
    );
    way_ram #(.payload_t(line_t)) u_line1 (
        .clk(clk), .i_raddr(rd_index), .i_waddr(wr_index),
        .i_we(line_we[1]), .i_wdata(refill_line), .o_rdata(line1)
    );

    icache_lookup u_lookup (
        .i_req_addr(req_addr_q), .i_tag0(tag0), .i_tag1(tag1), .i_valid(valid),
        .i_line0(line0), .i_line1(line1),
        .o_hit(hit), .o_hit_way(hit_way), .o_word(lookup_word)
    );

    icache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .i_req_valid(i_req_valid), .i_req_addr(i_req_addr), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp_fault(o_resp_fault),
        .i_cacop_valid(i_cacop_valid), .i_cacop_code(i_cacop_code),
        .i_cacop_addr(i_cacop_addr), .o_cacop_ready(o_cacop_ready),
        .o_cacop_done(o_cacop_done),
        .o_rd_index(rd_index), .o_wr_index(wr_index), .o_req_addr_q(req_addr_q),
        .o_valid(valid), .i_hit(hit), .i_hit_way(hit_way),
        .o_tag_we(tag_we), .o_line_we(line_we), .o_refill_start(refill_start),
        .i_line_valid(line_valid), .o_data_from_refill(data_from_refill)
    );

    refill_engine u_refill (
        .clk(clk), .rstn(rstn),
        .i_start(refill_start), .i_line_addr(req_addr_q),
        .o_line(refill_line), .o_line_valid(line_valid),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack)
    );

endmodule

// ==== bench/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model #(
    parameter logic [31:0] SEED = 32'hb095,
    parameter logic [31:0] MASK = 32'h5a5a0000
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic [31:0] i_wb_adr,
    output logic [31:0] o_wb_dat,
    output logic        o_wb_ack
);

    logic [31:0] rng_q;
    logic [1:0]  wait_q;    // wait states left in this beat
    logic        busy_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // read only, every byte address returns itself xor the mask
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rng_q    <= SEED;
            wait_q   <= '0;
            busy_q   <= 1'b0;
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
        end else begin
            o_wb_ack <= 1'b0;   // ack lasts one cycle
            if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= rng_q[1:0];   // 0 to 3 extra cycles
                    rng_q  <= xorshift(rng_q);
                end else if (wait_q == 2'd0) begin
                    busy_q   <= 1'b0;
                    o_wb_ack <= 1'b1;
                    o_wb_dat <= i_wb_adr ^ MASK;
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

// ==== bench/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache;
    import icache_pkg::*;

    localparam int          TIMEOUT = 200;            // cycles allowed per wait
    localparam logic [31:0] PATTERN = 32'h5a5a0000;   // memory word = address xor this
    localparam logic [31:0] SEED    = 32'hb095;

    logic        clk;
    logic        rstn;
    logic        req_valid, req_ready, resp_valid, resp_fault;
    logic [31:0] req_addr, resp_data;
    logic        cacop_valid, cacop_ready, cacop_done;
    cacop_code_t cacop_code;
    logic [31:0] cacop_addr;
    logic        wb_cyc, wb_stb, wb_ack;
    logic [31:0] wb_adr, wb_dat;

    int          cycle_n = 0;
    int          cyc_rises = 0;
    int          cyc_rise_cycle = 0;
    int          last_ack_cycle = 0;
    logic        cyc_prev = 1'b0;
    logic [31:0] beat_adr [$];     // addresses of acked beats

    icache_top dut (
        .clk(clk), .rstn(rstn),
        .i_req_valid(req_valid), .i_req_addr(req_addr), .o_req_ready(req_ready),
        .o_resp_valid(resp_valid), .o_resp_data(resp_data), .o_resp_fault(resp_fault),
        .i_cacop_valid(cacop_valid), .i_cacop_code(cacop_code), .i_cacop_addr(cacop_addr),
        .o_cacop_ready(cacop_ready), .o_cacop_done(cacop_done),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr),
        .i_wb_dat(wb_dat), .i_wb_ack(wb_ack)
    );

    wb_mem_model #(.SEED(SEED), .MASK(PATTERN)) u_mem (
        .clk(clk), .rstn(rstn),
        .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_adr(wb_adr),
        .o_wb_dat(wb_dat), .o_wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle_n <= cycle_n + 1;

    // bus monitor, sampled mid-cycle
    always @(negedge clk) begin
        check(32'(wb_stb), 32'(wb_cyc), "stb together with cyc");
        if (wb_cyc && !cyc_prev) begin
            cyc_rises      = cyc_rises + 1;
            cyc_rise_cycle = cycle_n;
        end
        cyc_prev = wb_cyc;
        if (wb_cyc && wb_stb && wb_ack) begin
            beat_adr.push_back(wb_adr);
            last_ack_cycle = cycle_n;
        end
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run aborted");
    endtask

    task automatic fetch(input logic [31:0] addr, input int exp_miss, input int exp_fault);
        int          rises_before;
        int          n;
        int          acc_cycle;
        logic [31:0] exp_word;
        rises_before = cyc_rises;
        beat_adr.delete();
        exp_word = (exp_fault != 0) ? 32'h0 : addr ^ PATTERN;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        n = 0;
        while (!req_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the fetch to be accepted");
        end
        @(negedge clk);        // accepted at the edge just passed
        req_valid = 1'b0;
        acc_cycle = cycle_n;   // the lookup cycle
        n = 1;
        while (!resp_valid) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the fetch response");
        end
        check(resp_data, exp_word, "response data");
        check(32'(resp_fault), 32'(exp_fault), "fault flag");
        check(32'(cyc_rises != rises_before), 32'(exp_miss), "miss flag");
        if (cyc_rises == rises_before) begin
            check(n, 1, "hit or fault latency");
        end else begin
            check(beat_adr.size(), 4, "beats per refill");
            for (int i = 0; i < 4; i++) begin
                check(beat_adr[i], {addr[31:4], 4'h0} + 32'(4 * i), "beat address");
            end
            check(cyc_rise_cycle, acc_cycle + 1, "cyc rise after lookup");
            check(cycle_n, last_ack_cycle + 1, "response after last ack");
        end
    endtask

    // four back-to-back fetches across one cached line
    task automatic stream(input logic [31:0] base);
        int rises_before;
        int n;
        rises_before = cyc_rises;
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = base;
        n = 0;
        while (!req_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the first streamed fetch");
        end
        for (int i = 1; i <= 4; i++) begin
            @(negedge clk);
            check(32'(resp_valid), 1, "streamed response valid");
            check(resp_data, (base + 32'(4 * (i - 1))) ^ PATTERN, "streamed data");
            if (i == 4) begin
                req_valid = 1'b0;
            end else begin
                req_addr = base + 32'(4 * i);
                check(32'(req_ready), 1, "acceptance on consecutive cycle");
            end
        end
        check(cyc_rises, rises_before, "no bus cycle while streaming");
    endtask

    task automatic cacop_op(input cacop_code_t code, input logic [31:0] addr);
        int n;
        @(negedge clk);
        cacop_valid = 1'b1;
        cacop_code  = code;
        cacop_addr  = addr;
        n = 0;
        while (!cacop_ready) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the cache operation to be accepted");
        end
        @(negedge clk);
        cacop_valid = 1'b0;
        n = 1;
        while (!cacop_done) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("timeout waiting for the cache operation to finish");
        end
        check(n, 2, "cacop done latency");
    endtask

    initial begin
        int          fd;
        int          ops;
        int          fields;
        int          miss;
        int          fault;
        logic [47:0] kind;
        logic [31:0] addr;
        string       line;
        rstn        = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        cacop_valid = 1'b0;
        cacop_code  = CACOP_INDEX_INV;
        cacop_addr  = '0;
        ops         = 0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check(32'(resp_valid | cacop_done | wb_cyc | req_ready), 0, "outputs low in reset");
        end
        rstn = 1'b1;
        @(negedge clk);
        check(32'(resp_valid | cacop_done | wb_cyc), 0, "outputs low right after reset");
        check(32'(req_ready), 1, "ready in the first cycle after reset");
        fd = $fopen("bench/icache_cases.txt", "r");
        if (fd == 0) begin
            abort_run("could not open bench/icache_cases.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin   // skip comments and blanks
                fields = $sscanf(line, "%s %h %d %d", kind, addr, miss, fault);
                check(fields, 4, "fields in case line");
                case (kind)
                    48'("fetch"):  fetch(addr, miss, fault);
                    48'("stream"): stream(addr);
                    48'("idxinv"): cacop_op(CACOP_INDEX_INV, addr);
                    48'("hitinv"): cacop_op(CACOP_HIT_INV, addr);
                    default:       abort_run("unknown operation kind in the case file");
                endcase
                ops++;
            end
        end
        $fclose(fd);
        if (ops > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run("the case file held no operations");
        end
    end

endmodule

// ==== bench/icache_cases.txt ====
# kind address(hex) miss fault, where miss and fault are the expected flags (0 or 1)
# kinds: fetch, stream (four back-to-back words of one line), idxinv, hitinv
fetch  00001010 1 0
fetch  00001010 0 0
stream 00001010 0 0
fetch  00002010 1 0
fetch  00001010 0 0
fetch  00003010 1 0
fetch  0000101c 0 0
fetch  00002010 1 0
fetch  00001012 0 1
fetch  00004020 1 0
idxinv 00004020 0 0
fetch  00004024 1 0
hitinv 00004020 0 0
fetch  00004028 1 0
hitinv 00005020 0 0
fetch  0000402c 0 0
fetch  00001014 0 0

// ==== all.f ====
rtl/icache_pkg.sv
rtl/way_ram.sv
rtl/icache_lookup.sv
rtl/refill_engine.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
bench/wb_mem_model.sv
bench/tb_icache.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/1ps
TOP      := tb_icache
FILELIST := all.f
LOG      := sim.log
PASS_MSG := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
